// File: sd_dat_read.f
+incdir+include
verilog/sd_read_pkg.sv
verilog/sd_read_ctrl.sv
verilog/sd_nibble_assembler.sv
verilog/sd_crc16_lanes.sv
verilog/sd_dat_read.sv
verification/sd_card_model.sv
verification/tb_sd_dat_read.sv

// File: Makefile
VERILATOR  ?= verilator
TB_TOP     ?= tb_sd_dat_read
RTL_TOP    ?= sd_dat_read
FILELIST   ?= sd_dat_read.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

RTL_SRCS = verilog/sd_read_pkg.sv verilog/sd_read_ctrl.sv \
           verilog/sd_nibble_assembler.sv verilog/sd_crc16_lanes.sv \
           verilog/sd_dat_read.sv
TB_SRCS  = verification/sd_card_model.sv verification/tb_sd_dat_read.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+include --top-module $(RTL_TOP) $(RTL_SRCS)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(RTL_SRCS) $(TB_SRCS) include/sd_read_macros.svh
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "failure reported in $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "no result found in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/tb_sd_dat_read.sv
`timescale 1ns/1ps

module tb_sd_dat_read;

  import sd_read_pkg::*;

  localparam int         TIMEOUT  = 2000;
  localparam int         NUM_ROWS = 5;
  localparam logic [2:0] NO_LANE  = 3'd7;

  typedef struct packed {
    byte_addr_t bytes;
    block_cnt_t blocks;
    logic [2:0] bad_lane;
    logic       bad_end;
    logic       hold_start;
    logic       exp_ok;
    block_cnt_t exp_count;
  } test_row_t;

  logic       i_clk = 1'b0;
  logic       i_rst_n;
  logic       i_trans_start;
  byte_addr_t i_block_bytes;
  block_cnt_t i_block_count;
  nibble_t    i_sd_data;
  byte_t      o_rd_data;
  byte_addr_t o_rd_addr;
  logic       o_wr_en;
  logic       o_reading;
  logic       o_busy;
  logic       o_done;
  logic       o_ok;
  block_cnt_t o_block_count;

  logic       card_send;
  logic [2:0] card_lane;
  logic       card_bad_end;
  logic       card_exp_valid;
  byte_t      card_exp_byte;
  logic       card_active;

  test_row_t  rows [NUM_ROWS];
  string      row_names [NUM_ROWS];
  byte_t      exp_q [$];
  byte_addr_t exp_addr = '0;
  logic       flush_q;
  int         main_errors = 0;
  int         sb_errors = 0;
  int         sb_writes = 0;
  int         sb_reading = 0;
  int         tests_run = 0;
  int         tests_failed = 0;

  always #50 i_clk = ~i_clk;

  sd_dat_read sd_dat_read_inst (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_trans_start(i_trans_start),
    .i_block_bytes(i_block_bytes), .i_block_count(i_block_count), .i_sd_data(i_sd_data),
    .o_rd_data(o_rd_data), .o_rd_addr(o_rd_addr), .o_wr_en(o_wr_en), .o_reading(o_reading),
    .o_busy(o_busy), .o_done(o_done), .o_ok(o_ok), .o_block_count(o_block_count)
  );

  sd_card_model sd_card_model_inst (
    .i_clk(i_clk), .i_send(card_send), .i_block_bytes(i_block_bytes),
    .i_block_count(i_block_count), .i_bad_lane(card_lane), .i_bad_end(card_bad_end),
    .o_sd_data(i_sd_data), .o_exp_valid(card_exp_valid), .o_exp_byte(card_exp_byte),
    .o_active(card_active)
  );

  function automatic int total_errors();
    return main_errors + sb_errors;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("FAIL %0t %s expected %0h actual %0h", $time, name, expected, actual);
      main_errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    read_state_e st;
    st = sd_dat_read_inst.sd_read_ctrl_inst.state;
    $display("timeout at %0t waiting for %s, controller in %s", $time, what, st.name());
    main_errors++;
  endtask

  task automatic wait_for_busy();
    int cycles;
    cycles = 0;
    do begin
      @(negedge i_clk);
      cycles++;
    end while (!o_busy && cycles < TIMEOUT);
    assert (o_busy) else report_timeout("o_busy to rise");
  endtask

  // o_ok and o_block_count are only valid in the done cycle
  task automatic wait_for_done(input logic exp_ok, input block_cnt_t exp_count);
    int cycles;
    cycles = 0;
    do begin
      @(negedge i_clk);
      cycles++;
    end while (!o_done && cycles < TIMEOUT);
    assert (o_done) else report_timeout("o_done");
    if (o_done) begin
      check_value("o_ok", exp_ok, o_ok);
      check_value("o_block_count", exp_count, o_block_count);
      check_value("o_busy", 32'd0, o_busy);
    end
  endtask

  task automatic wait_for_card();
    int cycles;
    cycles = 0;
    do begin
      @(negedge i_clk);
      cycles++;
    end while (card_active && cycles < TIMEOUT);
    assert (!card_active) else report_timeout("the card model to go idle");
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    tests_run++;
    if (total_errors() == errs_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", num, name, total_errors() - errs_before);
    end
  endtask

  task automatic run_row(input int idx);
    test_row_t row;
    int        errs_before;
    int        writes_before;
    int        reading_before;
    int        exp_writes;
    row            = rows[idx];
    errs_before    = total_errors();
    writes_before  = sb_writes;
    reading_before = sb_reading;
    // start input still high from the last transfer so there is no edge
    if (row.hold_start) begin
      for (int i = 0; i < 50; i++) begin
        @(negedge i_clk);
        check_value("o_busy", 32'd0, o_busy);
      end
    end
    @(posedge i_clk);
    i_trans_start <= 1'b0;
    i_block_bytes <= row.bytes;
    i_block_count <= row.blocks;
    card_lane     <= row.bad_lane;
    card_bad_end  <= row.bad_end;
    @(posedge i_clk);
    i_trans_start <= 1'b1;
    card_send     <= 1'b1;
    @(posedge i_clk);
    card_send <= 1'b0;
    wait_for_busy();
    wait_for_done(row.exp_ok, row.exp_count);
    wait_for_card();
    // a failing block is still written but later blocks are never read
    exp_writes = int'(row.bytes) * int'(row.exp_count + (row.exp_ok ? 32'd0 : 32'd1));
    check_value("o_wr_en count", exp_writes, sb_writes - writes_before);
    // two nibble cycles of data phase for every byte of a block that is read
    check_value("o_reading cycles", 2 * exp_writes, sb_reading - reading_before);
    if (row.exp_ok) begin
      check_value("bytes never written", 32'd0, exp_q.size());
    end
    @(posedge i_clk);
    flush_q <= 1'b1;
    @(posedge i_clk);
    flush_q <= 1'b0;
    report_test(idx + 2, row_names[idx], errs_before);
  endtask

  // byte and address check on every write strobe and a count of data-phase cycles
  always @(negedge i_clk) begin : scoreboard
    byte_t exp_byte;
    if (flush_q) begin
      exp_q.delete();
      exp_addr = '0;
    end
    if (card_exp_valid) begin
      exp_q.push_back(card_exp_byte);
    end
    if (o_reading) begin
      sb_reading++;
    end
    if (o_wr_en) begin
      sb_writes++;
      assert (exp_q.size() > 0) else begin
        $display("o_wr_en pulsed at %0t with no byte left to expect", $time);
        sb_errors++;
      end
      if (exp_q.size() > 0) begin
        exp_byte = exp_q.pop_front();
        assert (o_rd_data === exp_byte) else begin
          $display("FAIL %0t o_rd_data expected %02h actual %02h", $time, exp_byte, o_rd_data);
          sb_errors++;
        end
      end
      assert (o_rd_addr === exp_addr) else begin
        $display("FAIL %0t o_rd_addr expected %0d actual %0d", $time, exp_addr, o_rd_addr);
        sb_errors++;
      end
      exp_addr = (exp_addr == i_block_bytes - byte_addr_t'(1)) ? '0
                                                               : exp_addr + byte_addr_t'(1);
    end
  end

  initial begin
    int errs;
    i_rst_n       <= 1'b0;
    i_trans_start <= 1'b0;
    i_block_bytes <= '0;
    i_block_count <= '0;
    card_send     <= 1'b0;
    card_lane     <= NO_LANE;
    card_bad_end  <= 1'b0;
    flush_q       <= 1'b0;
    // bytes, blocks, bad lane, bad end, hold start, ok, good blocks
    rows[0] = '{10'd16, 32'd1, NO_LANE, 1'b0, 1'b0, 1'b1, 32'd1};
    rows[1] = '{10'd8, 32'd3, NO_LANE, 1'b0, 1'b0, 1'b1, 32'd3};
    rows[2] = '{10'd8, 32'd2, 3'd2, 1'b0, 1'b0, 1'b0, 32'd0};
    rows[3] = '{10'd12, 32'd1, NO_LANE, 1'b1, 1'b0, 1'b0, 32'd0};
    rows[4] = '{10'd16, 32'd2, NO_LANE, 1'b0, 1'b1, 1'b1, 32'd2};
    row_names[0] = "single 16-byte block";
    row_names[1] = "three 8-byte blocks";
    row_names[2] = "bad CRC on lane 2";
    row_names[3] = "bad end nibble";
    row_names[4] = "held start, then fresh edge";
    repeat (16) @(posedge i_clk);
    i_rst_n <= 1'b1;
    errs = total_errors();
    for (int i = 0; i < 4; i++) begin
      @(negedge i_clk);
      check_value("o_busy", 32'd0, o_busy);
      check_value("o_done", 32'd0, o_done);
      check_value("o_ok", 32'd0, o_ok);
      check_value("o_wr_en", 32'd0, o_wr_en);
      check_value("o_reading", 32'd0, o_reading);
      check_value("o_block_count", 32'd0, o_block_count);
    end
    report_test(1, "reset state", errs);
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    $display("summary: %0d tests, %0d failed, %0d check errors",
             tests_run, tests_failed, total_errors());
    if (total_errors() == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: verification/sd_card_model.sv
`timescale 1ns/1ps

`include "sd_read_macros.svh"

module sd_card_model (
  input  logic                     i_clk,
  input  logic                     i_send,
  input  sd_read_pkg::byte_addr_t  i_block_bytes,
  input  sd_read_pkg::block_cnt_t  i_block_count,
  input  logic [2:0]               i_bad_lane,
  input  logic                     i_bad_end,
  output sd_read_pkg::nibble_t     o_sd_data,
  output logic                     o_exp_valid,
  output sd_read_pkg::byte_t       o_exp_byte,
  output logic                     o_active
);

  import sd_read_pkg::*;

  logic [15:0] lfsr;
  crc16_t      crc [`SD_LANES];

  // galois form, taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one step for every bit taken
  task automatic take_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[6:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic put_nibble(input nibble_t nib, input logic exp_valid, input byte_t exp_byte);
    @(posedge i_clk);
    o_sd_data   <= nib;
    o_exp_valid <= exp_valid;
    o_exp_byte  <= exp_byte;
  endtask

  // each lane runs its own CRC-16, x^16 + x^12 + x^5 + 1, msb first
  task automatic put_data(input nibble_t nib, input logic exp_valid, input byte_t exp_byte);
    for (int l = 0; l < `SD_LANES; l++) begin
      crc[l] = {crc[l][14:0], 1'b0} ^ ((crc[l][15] ^ nib[l]) ? 16'h1021 : 16'h0000);
    end
    put_nibble(nib, exp_valid, exp_byte);
  endtask

  task automatic send_block(input byte_addr_t nbytes, input logic [2:0] bad_lane,
                            input logic bad_end);
    logic [7:0] gap;
    logic [7:0] data;
    nibble_t    nib;
    take_bits(3, gap);
    // idle gap of 1 to 8 cycles, then the start nibble
    for (int i = 0; i <= int'(gap); i++) begin
      put_nibble('1, 1'b0, '0);
    end
    put_nibble('0, 1'b0, '0);
    for (int l = 0; l < `SD_LANES; l++) begin
      crc[l] = '0;
    end
    for (int i = 0; i < int'(nbytes); i++) begin
      take_bits(8, data);
      put_data(data[7:4], 1'b0, '0);
      put_data(data[3:0], 1'b1, data);
    end
    if (bad_lane < 3'(`SD_LANES)) begin
      crc[bad_lane[1:0]][7] = ~crc[bad_lane[1:0]][7];
    end
    for (int k = `SD_CRC_LEN - 1; k >= 0; k--) begin
      for (int l = 0; l < `SD_LANES; l++) begin
        nib[l] = crc[l][k];
      end
      put_nibble(nib, 1'b0, '0);
    end
    // end bit, lane 3 held low for a broken end nibble
    put_nibble(bad_end ? 4'b0111 : 4'b1111, 1'b0, '0);
  endtask

  initial begin
    block_cnt_t nblk;
    byte_addr_t nbytes;
    logic [2:0] lane;
    logic       bad_end;
    lfsr = 16'd64;
    o_sd_data   <= '1;
    o_exp_valid <= 1'b0;
    o_exp_byte  <= '0;
    o_active    <= 1'b0;
    forever begin
      @(posedge i_clk);
      if (i_send) begin
        // a count of zero still sends one block
        nblk    = (i_block_count == '0) ? 32'd1 : i_block_count;
        nbytes  = i_block_bytes;
        lane    = i_bad_lane;
        bad_end = i_bad_end;
        o_active <= 1'b1;
        for (block_cnt_t b = 0; b < nblk; b++) begin
          // only the first block carries a fault
          send_block(nbytes, (b == 0) ? lane : 3'd7, (b == 0) && bad_end);
        end
        put_nibble('1, 1'b0, '0);
        o_active <= 1'b0;
      end
    end
  end

endmodule

// File: verilog/sd_dat_read.sv
`timescale 1ns/1ps

module sd_dat_read (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_trans_start,
  input  sd_read_pkg::byte_addr_t  i_block_bytes,
  input  sd_read_pkg::block_cnt_t  i_block_count,
  input  sd_read_pkg::nibble_t     i_sd_data,
  output sd_read_pkg::byte_t       o_rd_data,
  output sd_read_pkg::byte_addr_t  o_rd_addr,
  output logic                     o_wr_en,
  output logic                     o_reading,
  output logic                     o_busy,
  output logic                     o_done,
  output logic                     o_ok,
  output sd_read_pkg::block_cnt_t  o_block_count
);

  import sd_read_pkg::*;

  // sampled bus, two flops behind the pins
  nibble_t lane_data;

  logic start_bit;
  logic last_nibble;
  logic data_phase;
  logic crc_phase;
  logic block_start;
  logic crc_ok;

  sd_read_ctrl sd_read_ctrl_inst (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_trans_start  (i_trans_start),
    .i_block_count  (i_block_count),
    .i_start_bit    (start_bit),
    .i_last_nibble  (last_nibble),
    .i_crc_ok       (crc_ok),
    .o_data_phase   (data_phase),
    .o_crc_phase    (crc_phase),
    .o_block_start  (block_start),
    .o_reading      (o_reading),
    .o_busy         (o_busy),
    .o_done         (o_done),
    .o_ok           (o_ok),
    .o_block_count  (o_block_count)
  );

  sd_nibble_assembler sd_nibble_assembler_inst (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_sd_data      (i_sd_data),
    .i_block_bytes  (i_block_bytes),
    .i_data_phase   (data_phase),
    .i_block_start  (block_start),
    .o_lane_data    (lane_data),
    .o_start_bit    (start_bit),
    .o_last_nibble  (last_nibble),
    .o_rd_data      (o_rd_data),
    .o_rd_addr      (o_rd_addr),
    .o_wr_en        (o_wr_en)
  );

  sd_crc16_lanes sd_crc16_lanes_inst (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_lane_data    (lane_data),
    .i_block_start  (block_start),
    .i_data_phase   (data_phase),
    .i_crc_phase    (crc_phase),
    .o_crc_ok       (crc_ok)
  );

endmodule

// File: verilog/sd_crc16_lanes.sv
`timescale 1ns/1ps

`include "sd_read_macros.svh"

module sd_crc16_lanes (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  sd_read_pkg::nibble_t  i_lane_data,
  input  logic                  i_block_start,
  input  logic                  i_data_phase,
  input  logic                  i_crc_phase,
  output logic                  o_crc_ok
);

  import sd_read_pkg::*;

  // x^16 + x^12 + x^5 + 1
  localparam crc16_t CRC_POLY = 16'h1021;

  logic [`SD_LANES-1:0] lane_miss;
  logic                 r_crc_ok;

  genvar g;
  generate
    for (g = 0; g < `SD_LANES; g++) begin : g_lane
      crc16_t r_crc;
      logic   fb;

      assign fb = r_crc[`SD_CRC_LEN-1] ^ i_lane_data[g];

      always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
          r_crc <= '0;
        end else if (i_block_start) begin
          r_crc <= '0;
        end else if (i_data_phase) begin
          r_crc <= {r_crc[`SD_CRC_LEN-2:0], 1'b0} ^ (fb ? CRC_POLY : '0);
        end else if (i_crc_phase) begin
          // ones shift in, so the end nibble is compared against all ones
          r_crc <= {r_crc[`SD_CRC_LEN-2:0], 1'b1};
        end
      end

      assign lane_miss[g] = (r_crc[`SD_CRC_LEN-1] != i_lane_data[g]);
    end
  endgenerate

  // sticky mismatch flag for the current block
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_crc_ok <= 1'b0;
    end else if (i_block_start) begin
      r_crc_ok <= 1'b1;
    end else if (i_crc_phase && |lane_miss) begin
      r_crc_ok <= 1'b0;
    end
  end

  // include the nibble on the bus now, so the end nibble counts in its own cycle
  assign o_crc_ok = r_crc_ok && !(i_crc_phase && |lane_miss);

endmodule

// File: verilog/sd_nibble_assembler.sv
`timescale 1ns/1ps

`include "sd_read_macros.svh"

module sd_nibble_assembler (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  sd_read_pkg::nibble_t     i_sd_data,
  input  sd_read_pkg::byte_addr_t  i_block_bytes,
  input  logic                     i_data_phase,
  input  logic                     i_block_start,
  output sd_read_pkg::nibble_t     o_lane_data,
  output logic                     o_start_bit,
  output logic                     o_last_nibble,
  output sd_read_pkg::byte_t       o_rd_data,
  output sd_read_pkg::byte_addr_t  o_rd_addr,
  output logic                     o_wr_en
);

  import sd_read_pkg::*;

  localparam logic [`SD_ADDR_W:0] NIB_ONE = (`SD_ADDR_W+1)'(1);

  nibble_t r_sync1;
  nibble_t r_sync2;
  nibble_t r_high_nib;

  // nibble index in the block is one bit wider than the byte address
  logic [`SD_ADDR_W:0] r_nib_cnt;
  logic [`SD_ADDR_W:0] nib_last;

  // two flops from the pins that reset to the pulled-up idle level
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_sync1 <= '1;
      r_sync2 <= '1;
    end else begin
      r_sync1 <= i_sd_data;
      r_sync2 <= r_sync1;
    end
  end

  assign o_lane_data = r_sync2;
  assign o_start_bit = (r_sync2 == '0);

  assign nib_last      = {i_block_bytes, 1'b0} - NIB_ONE;
  assign o_last_nibble = i_data_phase && (r_nib_cnt == nib_last);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_nib_cnt <= '0;
    end else if (i_block_start) begin
      r_nib_cnt <= '0;
    end else if (i_data_phase) begin
      r_nib_cnt <= r_nib_cnt + NIB_ONE;
    end
  end

  // even nibbles are the high half of the byte
  always_ff @(posedge i_clk) begin
    if (i_data_phase && !r_nib_cnt[0]) begin
      r_high_nib <= r_sync2;
    end
    if (i_data_phase && r_nib_cnt[0]) begin
      o_rd_data <= {r_high_nib, r_sync2};
      o_rd_addr <= r_nib_cnt[`SD_ADDR_W:1];
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_wr_en <= 1'b0;
    end else begin
      o_wr_en <= i_data_phase && r_nib_cnt[0];
    end
  end

endmodule

// File: verilog/sd_read_ctrl.sv
`timescale 1ns/1ps

`include "sd_read_macros.svh"

module sd_read_ctrl (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_trans_start,
  input  sd_read_pkg::block_cnt_t  i_block_count,
  input  logic                     i_start_bit,
  input  logic                     i_last_nibble,
  input  logic                     i_crc_ok,
  output logic                     o_data_phase,
  output logic                     o_crc_phase,
  output logic                     o_block_start,
  output logic                     o_reading,
  output logic                     o_busy,
  output logic                     o_done,
  output logic                     o_ok,
  output sd_read_pkg::block_cnt_t  o_block_count
);

  import sd_read_pkg::*;

  // last CRC-phase count, the end nibble follows the sixteen CRC nibbles
  localparam logic [4:0] CRC_LAST = 5'(`SD_CRC_LEN);

  read_state_e state;
  read_state_e state_nxt;

  logic       r_trans_start;
  logic       start_edge;
  logic [4:0] r_crc_cnt;
  block_cnt_t r_block_cnt;
  block_cnt_t block_cnt_inc;

  // previous level of the start request, for edge detection
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_trans_start <= 1'b0;
    end else begin
      r_trans_start <= i_trans_start;
    end
  end

  assign start_edge    = i_trans_start & ~r_trans_start;
  assign block_cnt_inc = r_block_cnt + 32'd1;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (start_edge) begin
          state_nxt = WAIT_START;
        end
      end
      WAIT_START: begin
        // start bit seen on the sampled bus, data follows next cycle
        if (i_start_bit) begin
          state_nxt = DATA;
        end
      end
      DATA: begin
        if (i_last_nibble) begin
          state_nxt = CRC;
        end
      end
      CRC: begin
        // decide on the end nibble, crc_ok already covers it
        if (r_crc_cnt == CRC_LAST) begin
          state_nxt = i_crc_ok ? BLOCK_DONE : FAIL;
        end
      end
      BLOCK_DONE: begin
        // a requested count of zero still reads one block
        if (block_cnt_inc < i_block_count) begin
          state_nxt = WAIT_START;
        end else begin
          state_nxt = FINISH;
        end
      end
      FAIL: begin
        state_nxt = IDLE;
      end
      FINISH: begin
        state_nxt = IDLE;
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  // counts the 17 nibbles after the data
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_crc_cnt <= 5'd0;
    end else if (state == CRC) begin
      r_crc_cnt <= r_crc_cnt + 5'd1;
    end else begin
      r_crc_cnt <= 5'd0;
    end
  end

  // good blocks in the current transfer
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_block_cnt <= '0;
    end else if (state == IDLE && start_edge) begin
      r_block_cnt <= '0;
    end else if (state == BLOCK_DONE) begin
      r_block_cnt <= block_cnt_inc;
    end
  end

  assign o_data_phase  = (state == DATA);
  assign o_crc_phase   = (state == CRC);
  assign o_block_start = (state == WAIT_START) && i_start_bit;
  assign o_reading     = o_data_phase;

  // busy drops in the same cycle that done is raised
  assign o_done        = (state == FAIL) || (state == FINISH);
  assign o_ok          = (state == FINISH);
  assign o_busy        = (state != IDLE) && !o_done;
  assign o_block_count = r_block_cnt;

endmodule

// File: verilog/sd_read_pkg.sv
package sd_read_pkg;

  `include "sd_read_macros.svh"

  // one sample of the four data lanes
  typedef logic [`SD_NIBBLE_W-1:0] nibble_t;

  // two nibbles, high nibble first on the bus
  typedef logic [2*`SD_NIBBLE_W-1:0] byte_t;

  // byte address within a block, also the block length
  typedef logic [`SD_ADDR_W-1:0] byte_addr_t;

  typedef logic [31:0] block_cnt_t;

  // per-lane CRC-16 register
  typedef logic [`SD_CRC_LEN-1:0] crc16_t;

  typedef enum logic [2:0] {
    IDLE,
    WAIT_START,
    DATA,
    CRC,
    BLOCK_DONE,
    FAIL,
    FINISH
  } read_state_e;

endpackage

// File: include/sd_read_macros.svh
`ifndef SD_READ_MACROS_SVH
`define SD_READ_MACROS_SVH

// number of DAT lines on the card bus
`define SD_LANES 4

// one sample of all lanes
`define SD_NIBBLE_W 4

// CRC bits sent per lane after each block
`define SD_CRC_LEN 16

// byte address inside a block, up to 1023 bytes
`define SD_ADDR_W 10

`endif
